//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_sd_ctrl
FILELIST ?= tb.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(TOOL), run it and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/sd_pkg.sv
package sd_pkg;

  // Register offsets on the Wishbone slave port
  typedef enum logic [7:0] {
    ARGUMENT    = 8'h00,
    COMMAND     = 8'h04,
    STATUS      = 8'h08,
    RESP1       = 8'h0C,
    CONTROLLER  = 8'h1C,
    BLOCK       = 8'h20,
    POWER       = 8'h24,
    SOFTWARE    = 8'h28,
    TIMEOUT     = 8'h2C,
    NORMAL_ISR  = 8'h30,
    ERROR_ISR   = 8'h34,
    NORMAL_ISER = 8'h38,
    ERROR_ISER  = 8'h3C,
    CAPA        = 8'h48,
    CLOCK_D     = 8'h4C,
    BD_STATUS   = 8'h50,
    BD_ISR      = 8'h54,
    BD_ISER     = 8'h58,
    BD_RX       = 8'h60,
    BD_TX       = 8'h80
  } sd_reg_e;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } cmd_state_e;

  localparam int BD_DEPTH = 8;  // Words per descriptor queue

  localparam logic [7:0]  RESET_CLK_DIV = 8'd2;
  localparam logic [7:0]  POWER_WORD    = 8'h0F;  // 3.3 V, power on
  localparam logic [15:0] BLOCK_WORD    = 16'd512;
  localparam logic [15:0] CTRL_WORD     = 16'h0000;
  localparam logic [15:0] CAPA_WORD     = 16'h0000;

  // Status bit positions
  localparam int STAT_BUSY       = 0;
  localparam int NINT_CMD_DONE   = 0;
  localparam int EINT_CMD_REJECT = 0;
  localparam int BDINT_RX_OVF    = 0;
  localparam int BDINT_TX_OVF    = 1;

  localparam int CMD_FRAME_BITS = 48;

endpackage

//--- dv/tb_sd_ctrl.sv
`timescale 1ns/1ps

module tb_sd_ctrl;

  typedef enum logic [2:0] {OP_RD, OP_WRRD, OP_INT, OP_CMD, OP_FILL} op_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  adr;
    logic [31:0] dat;   // OP_CMD: bit 8 adds a rejected launch, bits 7:0 divider
    logic [31:0] want;
  } entry_t;

  localparam int N_ENTRIES = 31;

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i;
  logic [31:0] wb_dat_i;
  logic [7:0]  wb_adr_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i, wb_cyc_i, wb_stb_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o, sd_clk_o, sd_cmd_o, int_o;

  logic [31:0] lcg_state = 32'h82ac;
  logic [47:0] exp_frames [$];
  logic [47:0] frame_buf;
  int          nbits = 0;
  int          seen = 0;
  int          launched = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic [7:0]  rx_free = 8'd8;
  logic [7:0]  tx_free = 8'd8;
  logic [7:0]  cur_div = sd_pkg::RESET_CLK_DIV;
  time         last_rise = 0;

  entry_t tbl [N_ENTRIES] = '{
    '{OP_RD,   sd_pkg::POWER,       32'h0,         {24'h0, sd_pkg::POWER_WORD}},
    '{OP_RD,   sd_pkg::BLOCK,       32'h0,         {16'h0, sd_pkg::BLOCK_WORD}},
    '{OP_RD,   sd_pkg::CONTROLLER,  32'h0,         {16'h0, sd_pkg::CTRL_WORD}},
    '{OP_RD,   sd_pkg::CAPA,        32'h0,         {16'h0, sd_pkg::CAPA_WORD}},
    '{OP_RD,   sd_pkg::CLOCK_D,     32'h0,         {24'h0, sd_pkg::RESET_CLK_DIV}},
    '{OP_RD,   sd_pkg::BD_STATUS,   32'h0,         32'h0808},
    '{OP_INT,  8'h00,               32'h0,         32'h0},
    '{OP_WRRD, sd_pkg::TIMEOUT,     32'hdead_1234, 32'h1234},  // Upper half not stored
    '{OP_WRRD, sd_pkg::COMMAND,     32'h0000_2a05, 32'h2a05},
    '{OP_WRRD, sd_pkg::ERROR_ISER,  32'h0000_5a5a, 32'h5a5a},
    '{OP_WRRD, sd_pkg::BD_ISER,     32'h0000_00f0, 32'h00f0},
    '{OP_WRRD, sd_pkg::SOFTWARE,    32'h0000_0002, 32'h0002},
    '{OP_CMD,  8'h00,               32'h0,         32'h0},
    '{OP_CMD,  8'h00,               32'h0,         32'h0},
    '{OP_CMD,  8'h00,               32'h0,         32'h0},
    '{OP_CMD,  8'h00,               32'h3,         32'h0},
    '{OP_CMD,  8'h00,               32'h3,         32'h0},
    '{OP_CMD,  8'h00,               32'h3,         32'h0},
    '{OP_RD,   sd_pkg::NORMAL_ISR,  32'h0,         32'h1},
    '{OP_INT,  8'h00,               32'h0,         32'h0},   // Still masked
    '{OP_WRRD, sd_pkg::NORMAL_ISER, 32'h1,         32'h1},
    '{OP_INT,  8'h00,               32'h0,         32'h1},
    '{OP_WRRD, sd_pkg::NORMAL_ISR,  32'h1,         32'h0},   // Write one to clear
    '{OP_INT,  8'h00,               32'h0,         32'h0},
    '{OP_CMD,  8'h00,               32'h101,       32'h0},
    '{OP_RD,   sd_pkg::ERROR_ISR,   32'h0,         32'h1},
    '{OP_FILL, sd_pkg::BD_RX,       32'h0,         32'h1},
    '{OP_FILL, sd_pkg::BD_TX,       32'h0,         32'h3},
    '{OP_WRRD, sd_pkg::SOFTWARE,    32'h1,         32'h1},
    '{OP_RD,   sd_pkg::BD_STATUS,   32'h0,         32'h0808},
    '{OP_WRRD, sd_pkg::SOFTWARE,    32'h0,         32'h0}
  };

  sd_ctrl_top dut (
    .wb_clk_i, .wb_rst_i, .wb_dat_i, .wb_adr_i, .wb_sel_i, .wb_we_i, .wb_cyc_i, .wb_stb_i,
    .wb_dat_o, .wb_ack_o, .sd_clk_o, .sd_cmd_o, .int_o
  );

  always #50 wb_clk_i = ~wb_clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Serial CRC7, x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  function automatic logic [47:0] model_frame(input logic [5:0] idx, input logic [31:0] arg);
    return {2'b01, idx, arg, crc7({2'b01, idx, arg}), 1'b1};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // Called 1 ns after a rising edge, returns at the same point after ack
  task automatic access_reg(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
    int waited;
    waited = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do begin
      @(posedge wb_clk_i);
      #1;
      waited++;
    end while (!wb_ack_o && waited < 10);
    if (!wb_ack_o) begin
      failures++;
      $display("no ack for access to offset %h at %0t", adr, $time);
    end
    rdat = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    access_reg(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input logic [7:0] adr, output logic [31:0] rdat);
    access_reg(1'b0, adr, 32'h0, rdat);
  endtask

  task automatic compare_frame(input logic [47:0] got);
    logic [47:0] want;
    seen++;
    if (exp_frames.size() == 0) begin
      failures++;
      $display("SD command frame %h seen at %0t with no command launched", got, $time);
    end else begin
      want = exp_frames.pop_front();
      if (got !== want) begin
        mismatches++;
        $display("mismatch at %0t: sd_cmd_o frame got %h expected %h", $time, got, want);
      end
    end
  endtask

  // Command line monitor, a frame starts at the first 0 bit
  always @(posedge sd_clk_o) begin
    time period;
    period = $time - last_rise;
    last_rise = $time;
    if (nbits != 0 && period != 200 * (int'(cur_div) + 1)) begin  // Two divider periods
      mismatches++;
      $display("mismatch at %0t: sd_clk_o period got %0d expected %0d", $time, period,
               200 * (int'(cur_div) + 1));
    end
    if (nbits != 0 || sd_cmd_o == 1'b0) begin
      frame_buf = {frame_buf[46:0], sd_cmd_o};
      nbits = nbits + 1;
      if (nbits == sd_pkg::CMD_FRAME_BITS) begin
        nbits = 0;
        compare_frame(frame_buf);
      end
    end
  end

  task automatic run_command(input logic [7:0] div, input logic rej);
    logic [31:0] rdat;
    logic [31:0] arg;
    logic [5:0]  idx;
    int          polls;
    idx = 6'(next_rand());
    arg = next_rand();
    write_reg(sd_pkg::CLOCK_D, {24'h0, div});
    cur_div = div;
    write_reg(sd_pkg::COMMAND, {18'h0, idx, 8'h00});
    exp_frames.push_back(model_frame(idx, arg));
    launched++;
    write_reg(sd_pkg::ARGUMENT, arg);
    read_reg(sd_pkg::STATUS, rdat);
    check_value("STATUS busy", {31'h0, rdat[sd_pkg::STAT_BUSY]}, 32'h1);
    if (rej) begin
      arg = ~arg;  // Host ignores it, register still takes it
      write_reg(sd_pkg::ARGUMENT, arg);
    end
    polls = 0;
    do begin
      read_reg(sd_pkg::STATUS, rdat);
      polls++;
    end while (rdat[sd_pkg::STAT_BUSY] && polls < 200 * (int'(div) + 1));
    if (rdat[sd_pkg::STAT_BUSY]) begin
      failures++;
      $display("command with divider %0d still busy at %0t", div, $time);
    end
    read_reg(sd_pkg::ARGUMENT, rdat);
    check_value("ARGUMENT", rdat, arg);
    read_reg(sd_pkg::RESP1, rdat);
    check_value("RESP1", rdat, arg);
    check_value("frames seen", seen, launched);
  endtask

  task automatic fill_queue(input logic [7:0] adr, input logic [31:0] want_isr);
    logic [31:0] rdat;
    for (int i = 0; i < sd_pkg::BD_DEPTH + 1; i++) begin
      write_reg(adr, next_rand());
      if (adr == sd_pkg::BD_RX && rx_free != 0) rx_free--;
      if (adr == sd_pkg::BD_TX && tx_free != 0) tx_free--;
      read_reg(sd_pkg::BD_STATUS, rdat);
      check_value("BD_STATUS", rdat, {16'h0, rx_free, tx_free});
    end
    read_reg(sd_pkg::BD_ISR, rdat);
    check_value("BD_ISR", rdat, want_isr);
  endtask

  initial begin
    longint limit;
    int     div;
    limit = 10;
    foreach (tbl[i]) begin
      div = (tbl[i].op == OP_CMD) ? int'(tbl[i].dat[7:0]) : 0;
      limit += 48 * 2 * (div + 1) + 20;
    end
    limit = limit * 2;
    #(limit * 100);
    $display("watchdog expired after %0d clock cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] rdat;
    wb_rst_i = 1'b1;
    wb_dat_i = '0;
    wb_adr_i = '0;
    wb_sel_i = 4'hf;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    repeat (10) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    foreach (tbl[i]) begin
      case (tbl[i].op)
        OP_RD: begin
          read_reg(tbl[i].adr, rdat);
          check_value($sformatf("wb_dat_o (offset %h)", tbl[i].adr), rdat, tbl[i].want);
        end
        OP_WRRD: begin
          write_reg(tbl[i].adr, tbl[i].dat);
          read_reg(tbl[i].adr, rdat);
          check_value($sformatf("wb_dat_o (offset %h)", tbl[i].adr), rdat, tbl[i].want);
        end
        OP_INT:  check_value("int_o", {31'h0, int_o}, tbl[i].want);
        OP_CMD:  run_command(tbl[i].dat[7:0], tbl[i].dat[8]);
        OP_FILL: fill_queue(tbl[i].adr, tbl[i].want);
        default: ;
      endcase
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- hdl/sd_bd_queue.sv
`timescale 1ns/1ps

module sd_bd_queue (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        flush_i,
  input  logic        push_i,
  input  logic [31:0] dat_i,
  input  logic        pop_i,
  output logic [31:0] dat_o,
  output logic [7:0]  free_o,
  output logic        ovf_o
);

  logic [31:0] mem [sd_pkg::BD_DEPTH];
  logic [$clog2(sd_pkg::BD_DEPTH)-1:0] wr_ptr;
  logic [$clog2(sd_pkg::BD_DEPTH)-1:0] rd_ptr;
  logic [$clog2(sd_pkg::BD_DEPTH):0]   count;
  logic full;
  logic push_ok;
  logic pop_ok;

  assign full    = (int'(count) == sd_pkg::BD_DEPTH);
  assign push_ok = push_i & ~full & ~flush_i;
  assign pop_ok  = pop_i & (count != '0) & ~flush_i;
  assign dat_o   = mem[rd_ptr];
  assign free_o  = 8'(sd_pkg::BD_DEPTH - int'(count));

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf_o  <= 1'b0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf_o  <= 1'b0;
    end else begin
      ovf_o  <= push_i & full;  // Word is dropped
      wr_ptr <= wr_ptr + push_ok;
      rd_ptr <= rd_ptr + pop_ok;
      count  <= count + push_ok - pop_ok;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (push_ok) mem[wr_ptr] <= dat_i;
  end

  a_count_max: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    int'(count) <= sd_pkg::BD_DEPTH);

endmodule

//--- hdl/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        soft_rst_i,
  input  logic        start_i,
  input  logic [5:0]  index_i,
  input  logic [31:0] arg_i,
  input  logic [7:0]  clock_div_i,
  output logic        sd_clk_o,
  output logic        sd_cmd_o,
  output logic        busy_o,
  output logic        done_o,
  output logic        reject_o
);

  sd_pkg::cmd_state_e state;
  logic [7:0] clk_cnt;
  logic       clk_fall;
  logic [sd_pkg::CMD_FRAME_BITS-1:0] shift;
  logic [5:0] bit_cnt;
  logic [6:0] crc;
  logic [6:0] crc_next;
  logic       fb;

  // x^7 + x^3 + 1
  assign fb       = shift[sd_pkg::CMD_FRAME_BITS-1] ^ crc[6];
  assign crc_next = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};

  assign clk_fall = (clk_cnt >= clock_div_i) & sd_clk_o;
  assign busy_o   = (state != sd_pkg::IDLE);

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      clk_cnt  <= '0;
      sd_clk_o <= 1'b0;
    end else if (clk_cnt >= clock_div_i) begin
      clk_cnt  <= '0;
      sd_clk_o <= ~sd_clk_o;
    end else begin
      clk_cnt <= clk_cnt + 8'd1;
    end
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state    <= sd_pkg::IDLE;
      sd_cmd_o <= 1'b1;
      bit_cnt  <= '0;
      crc      <= '0;
      done_o   <= 1'b0;
      reject_o <= 1'b0;
    end else if (soft_rst_i) begin
      state    <= sd_pkg::IDLE;
      sd_cmd_o <= 1'b1;
      done_o   <= 1'b0;
      reject_o <= 1'b0;
    end else begin
      done_o   <= 1'b0;
      reject_o <= start_i & busy_o;
      case (state)
        sd_pkg::IDLE: begin
          if (start_i) begin
            bit_cnt <= '0;
            crc     <= '0;
            state   <= sd_pkg::SHIFT;
          end
        end
        sd_pkg::SHIFT: begin
          if (clk_fall) begin
            sd_cmd_o <= shift[sd_pkg::CMD_FRAME_BITS-1];
            bit_cnt  <= bit_cnt + 6'd1;
            if (int'(bit_cnt) < sd_pkg::CMD_FRAME_BITS - 8) crc <= crc_next;
            if (int'(bit_cnt) == sd_pkg::CMD_FRAME_BITS - 1) state <= sd_pkg::DONE;
          end
        end
        sd_pkg::DONE: begin
          if (clk_fall) begin  // End bit period over
            done_o <= 1'b1;
            state  <= sd_pkg::IDLE;
          end
        end
        default: state <= sd_pkg::IDLE;
      endcase
    end
  end

  // Frame shifter, CRC spliced in after the 40 payload bits
  always_ff @(posedge wb_clk_i) begin
    if (state == sd_pkg::IDLE && start_i) begin
      shift <= {1'b0, 1'b1, index_i, arg_i, 7'h00, 1'b1};
    end else if (state == sd_pkg::SHIFT && clk_fall) begin
      if (int'(bit_cnt) == sd_pkg::CMD_FRAME_BITS - 9)
        shift <= {crc_next, 1'b1, 40'h0};
      else
        shift <= {shift[sd_pkg::CMD_FRAME_BITS-2:0], 1'b0};
    end
  end

  a_idle_high: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (state == sd_pkg::IDLE) |-> sd_cmd_o);

endmodule

//--- hdl/sd_ctrl_top.sv
`timescale 1ns/1ps

module sd_ctrl_top (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_dat_i,
  input  logic [7:0]  wb_adr_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        sd_clk_o,
  output logic        sd_cmd_o,
  output logic        int_o
);

  logic [15:0] status_word;
  logic [15:0] bd_status;
  logic [15:0] normal_isr, error_isr, normal_ien, error_ien, clr_mask;
  logic [7:0]  bd_isr, bd_ien, clock_div, soft_reset, rx_free, tx_free;
  logic [31:0] argument, bd_dat;
  logic [15:0] cmd_setting;
  logic cmd_start, rx_push, tx_push, nisr_clr, eisr_clr, bdisr_clr;
  logic cmd_busy, cmd_done, cmd_reject, rx_ovf, tx_ovf;

  always_comb begin
    status_word = '0;
    status_word[sd_pkg::STAT_BUSY] = cmd_busy;
  end

  assign bd_status = {rx_free, tx_free};

  sd_reg_wb u_regs (
    .wb_clk_i, .wb_rst_i, .wb_dat_i, .wb_adr_i, .wb_sel_i, .wb_we_i, .wb_cyc_i, .wb_stb_i,
    .wb_dat_o, .wb_ack_o,
    .status_i(status_word), .normal_isr_i(normal_isr), .error_isr_i(error_isr),
    .bd_status_i(bd_status), .bd_isr_i(bd_isr),
    .argument_o(argument), .cmd_setting_o(cmd_setting), .clock_div_o(clock_div),
    .soft_reset_o(soft_reset), .timeout_o(), .normal_ien_o(normal_ien),
    .error_ien_o(error_ien), .bd_ien_o(bd_ien), .cmd_start_o(cmd_start),
    .rx_push_o(rx_push), .tx_push_o(tx_push), .bd_dat_o(bd_dat),
    .nisr_clr_o(nisr_clr), .eisr_clr_o(eisr_clr), .bdisr_clr_o(bdisr_clr),
    .clr_mask_o(clr_mask)
  );

  // Pop reserved for a data engine
  sd_bd_queue rx_q (
    .wb_clk_i, .wb_rst_i, .flush_i(soft_reset[0]), .push_i(rx_push), .dat_i(bd_dat),
    .pop_i(1'b0), .dat_o(), .free_o(rx_free), .ovf_o(rx_ovf)
  );

  sd_bd_queue tx_q (
    .wb_clk_i, .wb_rst_i, .flush_i(soft_reset[0]), .push_i(tx_push), .dat_i(bd_dat),
    .pop_i(1'b0), .dat_o(), .free_o(tx_free), .ovf_o(tx_ovf)
  );

  sd_int_ctrl u_int (
    .wb_clk_i, .wb_rst_i, .cmd_done_i(cmd_done), .cmd_reject_i(cmd_reject),
    .rx_ovf_i(rx_ovf), .tx_ovf_i(tx_ovf), .nisr_clr_i(nisr_clr), .eisr_clr_i(eisr_clr),
    .bdisr_clr_i(bdisr_clr), .clr_mask_i(clr_mask), .normal_ien_i(normal_ien),
    .error_ien_i(error_ien), .bd_ien_i(bd_ien), .normal_isr_o(normal_isr),
    .error_isr_o(error_isr), .bd_isr_o(bd_isr), .int_o
  );

  // Index field sits in bits 13:8 of the command word
  sd_cmd_host u_cmd (
    .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_reset[0]), .start_i(cmd_start),
    .index_i(cmd_setting[13:8]), .arg_i(argument), .clock_div_i(clock_div),
    .sd_clk_o, .sd_cmd_o, .busy_o(cmd_busy), .done_o(cmd_done), .reject_o(cmd_reject)
  );

endmodule

//--- hdl/sd_int_ctrl.sv
`timescale 1ns/1ps

module sd_int_ctrl (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        cmd_done_i,
  input  logic        cmd_reject_i,
  input  logic        rx_ovf_i,
  input  logic        tx_ovf_i,
  input  logic        nisr_clr_i,
  input  logic        eisr_clr_i,
  input  logic        bdisr_clr_i,
  input  logic [15:0] clr_mask_i,
  input  logic [15:0] normal_ien_i,
  input  logic [15:0] error_ien_i,
  input  logic [7:0]  bd_ien_i,
  output logic [15:0] normal_isr_o,
  output logic [15:0] error_isr_o,
  output logic [7:0]  bd_isr_o,
  output logic        int_o
);

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      normal_isr_o <= '0;
      error_isr_o  <= '0;
      bd_isr_o     <= '0;
      int_o        <= 1'b0;
    end else begin
      // Clear first so a same-cycle event still lands
      if (nisr_clr_i) normal_isr_o <= normal_isr_o & ~clr_mask_i;
      if (eisr_clr_i) error_isr_o <= error_isr_o & ~clr_mask_i;
      if (bdisr_clr_i) bd_isr_o <= bd_isr_o & ~clr_mask_i[7:0];
      if (cmd_done_i) normal_isr_o[sd_pkg::NINT_CMD_DONE] <= 1'b1;
      if (cmd_reject_i) error_isr_o[sd_pkg::EINT_CMD_REJECT] <= 1'b1;
      if (rx_ovf_i) bd_isr_o[sd_pkg::BDINT_RX_OVF] <= 1'b1;
      if (tx_ovf_i) bd_isr_o[sd_pkg::BDINT_TX_OVF] <= 1'b1;
      int_o <= |(normal_isr_o & normal_ien_i) | |(error_isr_o & error_ien_i) |
               |(bd_isr_o & bd_ien_i);
    end
  end

endmodule

//--- sd_regs/sd_reg_wb.sv
`timescale 1ns/1ps

module sd_reg_wb (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_dat_i,
  input  logic [7:0]  wb_adr_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic [15:0] status_i,
  input  logic [15:0] normal_isr_i,
  input  logic [15:0] error_isr_i,
  input  logic [15:0] bd_status_i,
  input  logic [7:0]  bd_isr_i,
  output logic [31:0] argument_o,
  output logic [15:0] cmd_setting_o,
  output logic [7:0]  clock_div_o,
  output logic [7:0]  soft_reset_o,
  output logic [15:0] timeout_o,
  output logic [15:0] normal_ien_o,
  output logic [15:0] error_ien_o,
  output logic [7:0]  bd_ien_o,
  output logic        cmd_start_o,
  output logic        rx_push_o,
  output logic        tx_push_o,
  output logic [31:0] bd_dat_o,
  output logic        nisr_clr_o,
  output logic        eisr_clr_o,
  output logic        bdisr_clr_o,
  output logic [15:0] clr_mask_o
);

  logic        access;
  logic        acc_edge;   // First cycle of an access
  logic [31:0] sel_mask;
  logic [31:0] wr_dat;

  assign access   = wb_cyc_i & wb_stb_i;
  assign acc_edge = access & ~wb_ack_o;
  assign sel_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};
  assign wr_dat   = wb_dat_i & sel_mask;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o      <= 1'b0;
      argument_o    <= '0;
      cmd_setting_o <= '0;
      clock_div_o   <= sd_pkg::RESET_CLK_DIV;
      soft_reset_o  <= '0;
      timeout_o     <= '0;
      normal_ien_o  <= '0;
      error_ien_o   <= '0;
      bd_ien_o      <= '0;
      cmd_start_o   <= 1'b0;
      rx_push_o     <= 1'b0;
      tx_push_o     <= 1'b0;
      nisr_clr_o    <= 1'b0;
      eisr_clr_o    <= 1'b0;
      bdisr_clr_o   <= 1'b0;
    end else begin
      wb_ack_o    <= acc_edge;
      cmd_start_o <= 1'b0;  // Pulses last one cycle
      rx_push_o   <= 1'b0;
      tx_push_o   <= 1'b0;
      nisr_clr_o  <= 1'b0;
      eisr_clr_o  <= 1'b0;
      bdisr_clr_o <= 1'b0;
      if (acc_edge && wb_we_i) begin
        case (sd_pkg::sd_reg_e'(wb_adr_i))
          sd_pkg::ARGUMENT: begin
            argument_o  <= (argument_o & ~sel_mask) | wr_dat;
            cmd_start_o <= 1'b1;
          end
          sd_pkg::COMMAND:
            cmd_setting_o <= (cmd_setting_o & ~sel_mask[15:0]) | wr_dat[15:0];
          sd_pkg::SOFTWARE:    soft_reset_o <= (soft_reset_o & ~sel_mask[7:0]) | wr_dat[7:0];
          sd_pkg::TIMEOUT:     timeout_o <= (timeout_o & ~sel_mask[15:0]) | wr_dat[15:0];
          sd_pkg::NORMAL_ISER: normal_ien_o <= (normal_ien_o & ~sel_mask[15:0]) | wr_dat[15:0];
          sd_pkg::ERROR_ISER:  error_ien_o <= (error_ien_o & ~sel_mask[15:0]) | wr_dat[15:0];
          sd_pkg::BD_ISER:     bd_ien_o <= (bd_ien_o & ~sel_mask[7:0]) | wr_dat[7:0];
          sd_pkg::CLOCK_D:     clock_div_o <= (clock_div_o & ~sel_mask[7:0]) | wr_dat[7:0];
          sd_pkg::NORMAL_ISR:  nisr_clr_o <= 1'b1;
          sd_pkg::ERROR_ISR:   eisr_clr_o <= 1'b1;
          sd_pkg::BD_ISR:      bdisr_clr_o <= 1'b1;
          sd_pkg::BD_RX:       rx_push_o <= 1'b1;
          sd_pkg::BD_TX:       tx_push_o <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Descriptor word and clear mask ride along with their pulses
  always_ff @(posedge wb_clk_i) begin
    if (acc_edge && wb_we_i) begin
      bd_dat_o   <= wb_dat_i;
      clr_mask_o <= wr_dat[15:0];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (acc_edge) begin
      case (sd_pkg::sd_reg_e'(wb_adr_i))
        sd_pkg::ARGUMENT:    wb_dat_o <= argument_o;
        sd_pkg::COMMAND:     wb_dat_o <= {16'h0, cmd_setting_o};
        sd_pkg::STATUS:      wb_dat_o <= {16'h0, status_i};
        sd_pkg::RESP1:       wb_dat_o <= argument_o;  // Loopback, no response path
        sd_pkg::CONTROLLER:  wb_dat_o <= {16'h0, sd_pkg::CTRL_WORD};
        sd_pkg::BLOCK:       wb_dat_o <= {16'h0, sd_pkg::BLOCK_WORD};
        sd_pkg::POWER:       wb_dat_o <= {24'h0, sd_pkg::POWER_WORD};
        sd_pkg::SOFTWARE:    wb_dat_o <= {24'h0, soft_reset_o};
        sd_pkg::TIMEOUT:     wb_dat_o <= {16'h0, timeout_o};
        sd_pkg::NORMAL_ISR:  wb_dat_o <= {16'h0, normal_isr_i};
        sd_pkg::ERROR_ISR:   wb_dat_o <= {16'h0, error_isr_i};
        sd_pkg::NORMAL_ISER: wb_dat_o <= {16'h0, normal_ien_o};
        sd_pkg::ERROR_ISER:  wb_dat_o <= {16'h0, error_ien_o};
        sd_pkg::CAPA:        wb_dat_o <= {16'h0, sd_pkg::CAPA_WORD};
        sd_pkg::CLOCK_D:     wb_dat_o <= {24'h0, clock_div_o};
        sd_pkg::BD_STATUS:   wb_dat_o <= {16'h0, bd_status_i};
        sd_pkg::BD_ISR:      wb_dat_o <= {24'h0, bd_isr_i};
        sd_pkg::BD_ISER:     wb_dat_o <= {24'h0, bd_ien_o};
        default:             wb_dat_o <= 32'h0;
      endcase
    end
  end

  // Held stb must see ack drop between beats
  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

//--- tb.f
common/sd_pkg.sv
sd_regs/sd_reg_wb.sv
hdl/sd_bd_queue.sv
hdl/sd_int_ctrl.sv
hdl/sd_cmd_host.sv
hdl/sd_ctrl_top.sv
dv/tb_sd_ctrl.sv
